//--- Makefile
# Verilator build and run of the osf testbench

SIM := obj_dir/Vosf_subsystem_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): project.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module osf_subsystem_tb -f project.f

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- project.f
src/osf_pkg.sv
src/oversample_filter.sv
src/result_merger.sv
src/osf_subsystem.sv
testbench/osf_checker.sv
testbench/osf_subsystem_tb.sv

//--- src/osf_pkg.sv
package osf_pkg;

	//////////////////////////////
	// filter states
	//////////////////////////////

	// two bits covers all four phases of a channel
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,	// parked until activate
		ST_DELAY  = 2'd1,	// dropping settling samples
		ST_SAMPLE = 2'd2,	// building the running sum
		ST_SEND   = 2'd3	// one cycle result strobe
	} osf_state_t;

	//////////////////////////////
	// channel layout
	//////////////////////////////

	localparam int N_CH = 2;	// channel a and channel b
	localparam int W_CH = 1;	// tag width for N_CH channels

	// tag 0 is channel a, tag N_CH-1 is channel b
	// merger gives the lower tag priority on a collision

endpackage

//--- src/osf_subsystem.sv
module osf_subsystem #(
	parameter int W_DATA    = 18,	// sample width, signed
	parameter int W_EP      = 16,	// cycle delay width
	parameter int W_OSM     = 3,	// oversample mode width
	parameter int OSM_INIT  = 0,	// osm after reset
	parameter int CDLY_INIT = 0	// cycle delay after reset
) (
	input  logic                            clk_in,	// system clock
	input  logic                            osf_reset,	// sync reset, active high

	// channel a
	input  logic signed [W_DATA-1:0]        a_data,
	input  logic                            a_valid,
	input  logic                            a_activate,
	input  logic                            a_update_en,

	// channel b
	input  logic signed [W_DATA-1:0]        b_data,
	input  logic                            b_valid,
	input  logic                            b_activate,
	input  logic                            b_update_en,

	// frontpanel, shared by both channels
	input  logic        [W_OSM-1:0]         osm,
	input  logic        [W_EP-1:0]          cycle_delay,
	input  logic                            update,

	// merged result stream
	output logic signed [W_DATA-1:0]        out_data,
	output logic        [osf_pkg::W_CH-1:0] out_channel,
	output logic                            out_valid
);

	//////////////////////////////
	// filter results
	//////////////////////////////

	logic signed [W_DATA-1:0] ch_result [osf_pkg::N_CH];	// index 0 is a, 1 is b
	logic [osf_pkg::N_CH-1:0] ch_valid;	// result strobes

	//////////////////////////////
	// channel filters
	//////////////////////////////

	oversample_filter #(
		.W_DATA    (W_DATA),
		.W_EP      (W_EP),
		.W_OSM     (W_OSM),
		.OSM_INIT  (OSM_INIT),
		.CDLY_INIT (CDLY_INIT)
	) chan_a (
		.clk_in       (clk_in),
		.osf_reset    (osf_reset),
		.data         (a_data),
		.valid        (a_valid),
		.activate     (a_activate),
		.update_en    (a_update_en),
		.update       (update),
		.osm          (osm),
		.cycle_delay  (cycle_delay),
		.result       (ch_result[0]),
		.result_valid (ch_valid[0])
	);

	oversample_filter #(
		.W_DATA    (W_DATA),
		.W_EP      (W_EP),
		.W_OSM     (W_OSM),
		.OSM_INIT  (OSM_INIT),
		.CDLY_INIT (CDLY_INIT)
	) chan_b (
		.clk_in       (clk_in),
		.osf_reset    (osf_reset),
		.data         (b_data),
		.valid        (b_valid),
		.activate     (b_activate),
		.update_en    (b_update_en),
		.update       (update),
		.osm          (osm),
		.cycle_delay  (cycle_delay),
		.result       (ch_result[1]),
		.result_valid (ch_valid[1])
	);

	//////////////////////////////
	// merger
	//////////////////////////////

	result_merger #(
		.W_DATA (W_DATA)
	) merge (
		.clk_in      (clk_in),
		.osf_reset   (osf_reset),
		.a_result    (ch_result[0]),	// a wins on collision
		.a_valid     (ch_valid[0]),
		.b_result    (ch_result[1]),
		.b_valid     (ch_valid[1]),
		.out_data    (out_data),
		.out_channel (out_channel),
		.out_valid   (out_valid)
	);

endmodule

//--- src/oversample_filter.sv
module oversample_filter #(
	parameter int W_DATA    = 18,	// sample width, signed
	parameter int W_EP      = 16,	// cycle delay width
	parameter int W_OSM     = 3,	// oversample mode width
	parameter int OSM_INIT  = 0,	// osm after reset
	parameter int CDLY_INIT = 0	// cycle delay after reset
) (
	input  logic                     clk_in,	// system clock
	input  logic                     osf_reset,	// sync reset, active high

	input  logic signed [W_DATA-1:0] data,	// adc sample
	input  logic                     valid,	// one cycle strobe per sample

	input  logic                     activate,	// channel on
	input  logic                     update_en,	// arms the update strobe
	input  logic                     update,	// latch strobe for osm and delay
	input  logic        [W_OSM-1:0]  osm,	// log2 oversample ratio
	input  logic        [W_EP-1:0]   cycle_delay,	// samples dropped after each result

	output logic signed [W_DATA-1:0] result,	// averaged sample
	output logic                     result_valid	// one cycle strobe
);

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int MAX_OS = 2**W_OSM - 1;	// largest log2 ratio
	localparam int W_SUM  = W_DATA + MAX_OS;	// room for 2^MAX_OS samples
	// counter serves both the sample count and the delay count
	localparam int W_CNT  = (MAX_OS + 1 > W_EP) ? MAX_OS + 1 : W_EP;

	//////////////////////////////
	// internal signals
	//////////////////////////////

	osf_pkg::osf_state_t     state;	// current phase
	osf_pkg::osf_state_t     state_next;	// phase for next cycle

	logic [W_CNT-1:0]        count;	// samples seen in this phase
	logic signed [W_SUM-1:0] acc;	// running sum
	logic [W_OSM-1:0]        osm_cur;	// latched oversample mode
	logic [W_EP-1:0]         cdly_cur;	// latched cycle delay

	logic                    clear;	// local clear
	logic                    full;	// 2^osm samples summed
	logic                    delay_done;	// settling samples dropped
	logic                    accept;	// sample goes into the sum
	logic                    step;	// counter advances

	//////////////////////////////
	// control terms
	//////////////////////////////

	// deactivation behaves like a reset of the channel
	assign clear = osf_reset | ~activate;

	// count never passes 2^osm, so bit osm alone marks full
	assign full = count[osm_cur];

	assign delay_done = (count >= W_CNT'(cdly_cur));	// zero delay exits at once

	// the delay exit cycle already opens the next sum
	assign accept = valid & (((state == osf_pkg::ST_SAMPLE) & ~full) |
		((state == osf_pkg::ST_DELAY) & delay_done));

	// dropped settling samples are counted too
	assign step = accept | (valid & (state == osf_pkg::ST_DELAY));

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_next = state;	// hold by default
		case (state)
			osf_pkg::ST_IDLE: begin
				if (activate) begin
					state_next = osf_pkg::ST_SAMPLE;	// no delay on first pass
				end
			end
			osf_pkg::ST_DELAY: begin
				if (delay_done) begin
					state_next = osf_pkg::ST_SAMPLE;	// settling over
				end
			end
			osf_pkg::ST_SAMPLE: begin
				if (full) begin
					state_next = osf_pkg::ST_SEND;	// sum complete
				end
			end
			osf_pkg::ST_SEND: begin
				state_next = osf_pkg::ST_DELAY;	// strobe lasts one cycle
			end
			default: begin
				state_next = osf_pkg::ST_IDLE;
			end
		endcase
	end

	//////////////////////////////
	// state and counter
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clear) begin
			state <= osf_pkg::ST_IDLE;
			count <= '0;
		end else begin
			state <= state_next;
			if (state_next != state) begin
				// first sample of a new sum may land on the exit cycle
				count <= accept ? W_CNT'(1) : '0;
			end else if (step) begin
				count <= count + 1'b1;
			end
		end
	end

	//////////////////////////////
	// accumulator
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clear) begin
			acc <= '0;	// partial sum is lost
		end else if (state == osf_pkg::ST_SEND) begin
			acc <= '0;	// result already taken
		end else if (accept) begin
			acc <= acc + W_SUM'(data);	// sign extended add
		end
	end

	//////////////////////////////
	// result
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clear) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= (state_next == osf_pkg::ST_SEND);	// high in send only
		end
	end

	// average taken from the full sum on the way into send
	always_ff @(posedge clk_in) begin
		if (state_next == osf_pkg::ST_SEND) begin
			result <= W_DATA'(acc >>> osm_cur);	// floor of sum / 2^osm
		end
	end

	//////////////////////////////
	// frontpanel parameters
	//////////////////////////////

	// survive deactivation, only a reset or an armed update changes them
	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			osm_cur  <= W_OSM'(OSM_INIT);
			cdly_cur <= W_EP'(CDLY_INIT);
		end else if (update & update_en) begin
			osm_cur  <= osm;	// used from next cycle
			cdly_cur <= cycle_delay;
		end
	end

endmodule

//--- src/result_merger.sv
module result_merger #(
	parameter int W_DATA = 18	// result width, signed
) (
	input  logic                            clk_in,	// system clock
	input  logic                            osf_reset,	// sync reset, active high

	input  logic signed [W_DATA-1:0]        a_result,	// channel a average
	input  logic                            a_valid,	// channel a strobe
	input  logic signed [W_DATA-1:0]        b_result,	// channel b average
	input  logic                            b_valid,	// channel b strobe

	output logic signed [W_DATA-1:0]        out_data,	// merged result
	output logic        [osf_pkg::W_CH-1:0] out_channel,	// source tag
	output logic                            out_valid	// one cycle strobe
);

	//////////////////////////////
	// tags
	//////////////////////////////

	localparam int unsigned LAST_CH = osf_pkg::N_CH - 1;	// index of channel b

	localparam logic [osf_pkg::W_CH-1:0] TAG_A = '0;	// first channel
	localparam logic [osf_pkg::W_CH-1:0] TAG_B = LAST_CH[osf_pkg::W_CH-1:0];

	//////////////////////////////
	// pending slot
	//////////////////////////////

	// one deep is enough, a channel strobes at most every third cycle
	logic signed [W_DATA-1:0] pend_data;	// channel b result that lost
	logic                     pend_valid;	// slot occupied

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			pend_valid <= 1'b0;
		end else if (a_valid & b_valid) begin
			pend_valid <= 1'b1;	// collision, b waits
		end else begin
			pend_valid <= 1'b0;	// drained this cycle
		end
	end

	always_ff @(posedge clk_in) begin
		if (a_valid & b_valid) begin
			pend_data <= b_result;
		end
	end

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= a_valid | b_valid | pend_valid;	// any source pending
		end
	end

	// fixed priority a, then held b, then fresh b
	always_ff @(posedge clk_in) begin
		if (a_valid) begin
			out_data    <= a_result;
			out_channel <= TAG_A;
		end else if (pend_valid) begin
			out_data    <= pend_data;	// one cycle late
			out_channel <= TAG_B;
		end else if (b_valid) begin
			out_data    <= b_result;
			out_channel <= TAG_B;
		end
	end

endmodule

//--- testbench/osf_checker.sv
module osf_checker (
	input logic                clk_in,	// filter clock
	input logic                osf_reset,	// sync reset, active high
	input logic                activate,	// channel on
	input logic                result_valid,	// result strobe
	input osf_pkg::osf_state_t state	// filter phase
);

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////
	// result strobe
	//////////////////////////////

	strobe_single: assert property (@(posedge clk_in) disable iff (osf_reset)
		result_valid |=> !result_valid)	// one cycle only
		else $error("result_valid stayed high for two cycles");

	strobe_in_send: assert property (@(posedge clk_in) disable iff (osf_reset)
		result_valid |-> (state == osf_pkg::ST_SEND))	// strobe tracks send
		else $error("result_valid high outside the send state");

	//////////////////////////////
	// deactivation
	//////////////////////////////

	// channel off parks the filter one edge later
	idle_when_off: assert property (@(posedge clk_in) disable iff (osf_reset)
		!activate |=> (state == osf_pkg::ST_IDLE))
		else $error("filter not idle after activate went low");

endmodule

// one checker per filter instance
bind oversample_filter osf_checker chk (
	.clk_in       (clk_in),
	.osf_reset    (osf_reset),
	.activate     (activate),
	.result_valid (result_valid),
	.state        (state)
);

//--- testbench/osf_subsystem_tb.sv
module osf_subsystem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int W_DATA      = 18;	// dut defaults
	localparam int W_EP        = 16;
	localparam int W_OSM       = 3;
	localparam int CYCLE_LIMIT = 1000;	// tests take about 500 cycles

	logic                     clk_in;
	logic                     osf_reset;
	logic signed [W_DATA-1:0] a_data;
	logic                     a_valid;
	logic                     a_activate;
	logic                     a_update_en;
	logic signed [W_DATA-1:0] b_data;
	logic                     b_valid;
	logic                     b_activate;
	logic                     b_update_en;
	logic [W_OSM-1:0]         osm;
	logic [W_EP-1:0]          cycle_delay;
	logic                     update;
	logic signed [W_DATA-1:0] out_data;
	logic [osf_pkg::W_CH-1:0] out_channel;
	logic                     out_valid;

	longint sum_a;	// model sum, channel a
	longint sum_b;	// model sum, channel b
	int     osm_a;	// model of latched osm
	int     osm_b;
	int     cycle_count;	// edges since start

	osf_subsystem dut (.*);	// default parameters

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;	// 40 ns period
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_in);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("test failed");
		$fatal(1, "cycle limit reached");
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic tick();
		@(posedge clk_in);
		#2;	// drive just after the edge
		a_valid = 1'b0;	// strobes last one cycle
		b_valid = 1'b0;
		update  = 1'b0;
	endtask

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (actual !== expected) begin
			$display("error: time %0t signal %s expected %0d actual %0d",
				$time, name, expected, actual);
			$display("test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// floor of sum / 2^shift
	function automatic logic signed [W_DATA-1:0] average(input longint sum, input int shift);
		longint avg;
		avg = sum >>> shift;
		return avg[W_DATA-1:0];
	endfunction

	task automatic latch_params(input int osm_val, input int cdly_val, input bit en_a,
		input bit en_b);
		tick();
		osm         = W_OSM'(osm_val);
		cycle_delay = W_EP'(cdly_val);
		a_update_en = en_a;
		b_update_en = en_b;
		update      = 1'b1;
		if (en_a) begin
			osm_a = osm_val;	// model follows the latch
		end
		if (en_b) begin
			osm_b = osm_val;
		end
	endtask

	// random gaps of 0 to 3 cycles, no result expected meanwhile
	task automatic feed_samples(input bit on_a, input bit on_b, input int n);
		logic [31:0] rnd;
		int          gap;
		for (int i = 0; i < n; i++) begin
			gap = $urandom % 4;
			repeat (gap + 1) begin
				tick();
				check_value("out_valid", 0, out_valid);
			end
			rnd     = $urandom;
			a_data  = rnd[W_DATA-1:0];
			rnd     = $urandom;
			b_data  = rnd[W_DATA-1:0];
			a_valid = on_a;
			b_valid = on_b;
			if (on_a) begin
				sum_a = sum_a + a_data;
			end
			if (on_b) begin
				sum_b = sum_b + b_data;
			end
		end
	endtask

	// latency counted from the last strobe drive
	task automatic wait_result(input int tag, input logic signed [W_DATA-1:0] expected,
		input int latency);
		int n;
		n = 0;
		do begin
			tick();
			n++;
		end while (!out_valid && n < 8);
		if (!out_valid) begin
			$display("no result appeared on out_valid within 8 cycles");
			$display("test failed");
			$fatal(1, "result missing");
		end else begin
			check_value("latency", latency, n);
			check_value("out_channel", tag, out_channel);
			check_value("out_data", expected, out_data);
		end
	endtask

	task automatic check_quiet(input int n);
		repeat (n) begin
			tick();
			check_value("out_valid", 0, out_valid);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic quiet_when_inactive();
		logic [31:0] rnd;
		repeat (10) begin
			tick();
			check_value("out_valid", 0, out_valid);
			rnd     = $urandom;
			a_data  = rnd[W_DATA-1:0];
			b_data  = ~rnd[W_DATA-1:0];
			a_valid = 1'b1;	// samples on both, channels off
			b_valid = 1'b1;
		end
		check_quiet(3);
	endtask

	task automatic average_osm_sweep();
		int modes [3] = '{2, 0, 5};
		tick();
		a_activate = 1'b1;
		foreach (modes[i]) begin
			latch_params(modes[i], 0, 1'b1, 1'b0);
			sum_a = 0;
			feed_samples(1'b1, 1'b0, 1 << modes[i]);
			wait_result(0, average(sum_a, osm_a), 3);
			check_quiet(4);	// exactly one result
		end
	endtask

	task automatic settling_delay_skip();
		latch_params(2, 3, 1'b1, 1'b0);
		sum_a = 0;
		feed_samples(1'b1, 1'b0, 4);
		wait_result(0, average(sum_a, osm_a), 3);
		feed_samples(1'b1, 1'b0, 3);	// dropped while settling
		sum_a = 0;
		feed_samples(1'b1, 1'b0, 4);
		wait_result(0, average(sum_a, osm_a), 3);
		check_quiet(2);
	endtask

	task automatic both_channels_collide();
		latch_params(2, 0, 1'b1, 1'b1);
		tick();
		b_activate = 1'b1;
		sum_a = 0;
		sum_b = 0;
		feed_samples(1'b1, 1'b1, 4);	// same strobe timing on a and b
		wait_result(0, average(sum_a, osm_a), 3);
		wait_result(1, average(sum_b, osm_b), 1);	// b held one cycle
		check_quiet(4);
	endtask

	task automatic update_and_activate_gating();
		latch_params(1, 0, 1'b1, 1'b0);	// b keeps osm 2
		sum_b = 0;
		feed_samples(1'b0, 1'b1, 4);
		wait_result(1, average(sum_b, osm_b), 3);
		sum_a = 0;
		feed_samples(1'b1, 1'b0, 1);	// partial sum on a
		tick();
		a_activate = 1'b0;	// partial sum lost
		tick();
		a_activate = 1'b1;
		sum_a = 0;
		feed_samples(1'b1, 1'b0, 2);
		wait_result(0, average(sum_a, osm_a), 3);
		check_quiet(4);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		osf_reset   = 1'b1;
		a_data      = '0;
		a_valid     = 1'b0;
		a_activate  = 1'b0;
		a_update_en = 1'b0;
		b_data      = '0;
		b_valid     = 1'b0;
		b_activate  = 1'b0;
		b_update_en = 1'b0;
		osm         = '0;
		cycle_delay = '0;
		update      = 1'b0;
		sum_a       = 0;
		sum_b       = 0;
		osm_a       = 0;	// OSM_INIT default
		osm_b       = 0;
		void'($urandom(32'ha8aa));	// single seed for the run
		repeat (3) @(posedge clk_in);
		#2;
		osf_reset = 1'b0;
		quiet_when_inactive();
		average_osm_sweep();
		settling_delay_skip();
		both_channels_collide();
		update_and_activate_gating();
		$display("test passed");
		$finish;
	end

endmodule
